// ==== Bender.yml ====
package:
  name: dram_channel

sources:
  - files:
      - logic/dram_cfg_pkg.sv
      - logic/dram_regs_pkg.sv
      - logic/dram_chan_regs.sv
      - logic/dram_addr_xlate.sv
      - logic/dram_mem_model.sv
      - logic/dram_channel_top.sv

  - target: simulation
    files:
      - verification/dram_channel_tb.sv

# top modules: dram_channel_top and, in simulation, dram_channel_tb

// ==== logic/dram_addr_xlate.sv ====
// dram channel address stage
// window check and base offset
`timescale 1ns/10ps
`default_nettype none

module dram_addr_xlate (
  // channel settings
  input  wire logic                                  enable_i,
  input  wire logic [dram_cfg_pkg::MEM_AW-1:0]       base_i,
  input  wire logic [dram_regs_pkg::LIMIT_W-1:0]     limit_i,

  // host commands
  input  wire logic                                  read_v_i,
  input  wire logic [dram_cfg_pkg::ADDR_W-1:0]       read_addr_i,
  input  wire logic                                  write_v_i,
  input  wire logic [dram_cfg_pkg::ADDR_W-1:0]       write_addr_i,
  input  wire logic                                  wdata_v_i,

  // to the memory
  output logic                                       mem_read_v_o,
  output logic      [dram_cfg_pkg::MEM_AW-1:0]       mem_read_paddr_o,
  output logic                                       mem_write_v_o,
  output logic      [dram_cfg_pkg::MEM_AW-1:0]       mem_write_paddr_o,

  // to the register block
  output logic                                       rd_reject_o,
  output logic                                       wr_reject_o
);

  localparam logic [dram_regs_pkg::LIMIT_W-1:0] WORD_BYTES =
    dram_regs_pkg::LIMIT_W'(dram_cfg_pkg::BYTES_PER_WORD);

  logic [dram_regs_pkg::LIMIT_W-1:0] rd_end;  // one past the last byte of the word
  logic [dram_regs_pkg::LIMIT_W-1:0] wr_end;
  logic                              rd_in_win;
  logic                              wr_in_win;
  logic                              rd_req;
  logic                              wr_req;

  // extra top bit keeps the end address from wrapping
  assign rd_end = {1'b0, read_addr_i} + WORD_BYTES;
  assign wr_end = {1'b0, write_addr_i} + WORD_BYTES;

  assign rd_in_win = (rd_end <= limit_i);
  assign wr_in_win = (wr_end <= limit_i);

  // a disabled channel ignores everything, a write needs its data present
  assign rd_req = enable_i && read_v_i;
  assign wr_req = enable_i && write_v_i && wdata_v_i;

  assign mem_read_v_o  = rd_req && rd_in_win;
  assign rd_reject_o   = rd_req && !rd_in_win;
  assign mem_write_v_o = wr_req && wr_in_win;
  assign wr_reject_o   = wr_req && !wr_in_win;

  // only the low bits matter, the sum wraps modulo MEM_BYTES
  assign mem_read_paddr_o  = base_i + read_addr_i[dram_cfg_pkg::MEM_AW-1:0];
  assign mem_write_paddr_o = base_i + write_addr_i[dram_cfg_pkg::MEM_AW-1:0];

endmodule

`default_nettype wire

// ==== logic/dram_cfg_pkg.sv ====
// dram channel geometry
// widths, array size and initial fill
`default_nettype none

package dram_cfg_pkg;

  // host side byte address, one 16-bit word
  localparam int ADDR_W = 16;

  // data word carried by read and write commands
  localparam int DATA_W = 32;
  localparam int BYTES_PER_WORD = DATA_W / 8;

  // physical array behind the channel
  localparam int MEM_BYTES = 4096;
  localparam int MEM_AW = $clog2(MEM_BYTES);  // physical byte index

  // every byte starts out holding the low bits of its own physical address
  function automatic logic [7:0] init_byte(input logic [MEM_AW-1:0] paddr);
    return paddr[7:0];
  endfunction

endpackage

`default_nettype wire

// ==== logic/dram_chan_regs.sv ====
// dram channel configuration registers
// enable, base, limit and event counters
`timescale 1ns/10ps
`default_nettype none

module dram_chan_regs (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_i,

  // host configuration port
  input  wire logic                                  cfg_we_i,
  input  wire logic [dram_regs_pkg::CFG_AW-1:0]      cfg_addr_i,
  input  wire logic [dram_regs_pkg::CFG_DW-1:0]      cfg_wdata_i,
  output logic      [dram_regs_pkg::CFG_DW-1:0]      cfg_rdata_o,

  // events from the address stage and memory
  input  wire logic                                  rd_accept_i,
  input  wire logic                                  wr_accept_i,
  input  wire logic                                  rd_reject_i,
  input  wire logic                                  wr_reject_i,

  // settings to the address stage
  output logic                                       enable_o,
  output logic      [dram_cfg_pkg::MEM_AW-1:0]       base_o,
  output logic      [dram_regs_pkg::LIMIT_W-1:0]     limit_o
);

  logic                                  enable_q;
  logic [dram_cfg_pkg::MEM_AW-1:0]       base_q;
  logic [dram_regs_pkg::LIMIT_W-1:0]     limit_q;
  logic [dram_regs_pkg::CNT_W-1:0]       rd_cnt_q;
  logic [dram_regs_pkg::CNT_W-1:0]       wr_cnt_q;
  logic [dram_regs_pkg::CNT_W-1:0]       err_cnt_q;

  logic [1:0]                            err_inc;  // both commands may be rejected at once
  logic                                  wr_ctrl;
  logic                                  wr_base;
  logic                                  wr_limit;
  logic                                  wr_err;

  // register write decode
  assign wr_ctrl  = cfg_we_i && (cfg_addr_i == dram_regs_pkg::REG_CTRL);
  assign wr_base  = cfg_we_i && (cfg_addr_i == dram_regs_pkg::REG_BASE);
  assign wr_limit = cfg_we_i && (cfg_addr_i == dram_regs_pkg::REG_LIMIT);
  assign wr_err   = cfg_we_i && (cfg_addr_i == dram_regs_pkg::REG_ERR_CNT);

  assign err_inc = {1'b0, rd_reject_i} + {1'b0, wr_reject_i};

  // control, base and limit
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      enable_q <= 1'b0;
      base_q   <= dram_regs_pkg::BASE_RESET;
      limit_q  <= dram_regs_pkg::LIMIT_RESET;
    end else begin
      if (wr_ctrl)
        enable_q <= cfg_wdata_i[0];
      if (wr_base)
        base_q <= cfg_wdata_i[dram_cfg_pkg::MEM_AW-1:0];
      if (wr_limit)
        limit_q <= cfg_wdata_i[dram_regs_pkg::LIMIT_W-1:0];
    end
  end

  // accepted read and write counters, host writes ignored
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_cnt_q <= '0;
      wr_cnt_q <= '0;
    end else begin
      if (rd_accept_i)
        rd_cnt_q <= rd_cnt_q + 1'b1;
      if (wr_accept_i)
        wr_cnt_q <= wr_cnt_q + 1'b1;
    end
  end

  // error counter, a host write clears it even if a reject lands in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_cnt_q <= '0;
    end else if (wr_err) begin
      err_cnt_q <= '0;
    end else if (err_inc != 2'd0) begin
      err_cnt_q <= err_cnt_q + dram_regs_pkg::CNT_W'(err_inc);
    end
  end

  // combinational readback, unmapped reads as zero
  always_comb begin
    case (cfg_addr_i)
      dram_regs_pkg::REG_CTRL:    cfg_rdata_o = dram_regs_pkg::CFG_DW'(enable_q);
      dram_regs_pkg::REG_BASE:    cfg_rdata_o = dram_regs_pkg::CFG_DW'(base_q);
      dram_regs_pkg::REG_LIMIT:   cfg_rdata_o = dram_regs_pkg::CFG_DW'(limit_q);
      dram_regs_pkg::REG_RD_CNT:  cfg_rdata_o = rd_cnt_q;
      dram_regs_pkg::REG_WR_CNT:  cfg_rdata_o = wr_cnt_q;
      dram_regs_pkg::REG_ERR_CNT: cfg_rdata_o = err_cnt_q;
      default:                    cfg_rdata_o = '0;
    endcase
  end

  assign enable_o = enable_q;
  assign base_o   = base_q;
  assign limit_o  = limit_q;

endmodule

`default_nettype wire

// ==== logic/dram_channel_top.sv ====
// dram channel top level
`timescale 1ns/10ps
`default_nettype none

module dram_channel_top (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_i,

  // command side
  input  wire logic                                  read_v_i,
  input  wire logic [dram_cfg_pkg::ADDR_W-1:0]       read_addr_i,
  input  wire logic                                  write_v_i,
  input  wire logic [dram_cfg_pkg::ADDR_W-1:0]       write_addr_i,
  input  wire logic                                  wdata_v_i,
  input  wire logic [dram_cfg_pkg::DATA_W-1:0]       wdata_i,
  output logic                                       wdata_yumi_o,
  output logic                                       rdata_v_o,
  output logic      [dram_cfg_pkg::DATA_W-1:0]       rdata_o,

  // configuration side
  input  wire logic                                  cfg_we_i,
  input  wire logic [dram_regs_pkg::CFG_AW-1:0]      cfg_addr_i,
  input  wire logic [dram_regs_pkg::CFG_DW-1:0]      cfg_wdata_i,
  output logic      [dram_regs_pkg::CFG_DW-1:0]      cfg_rdata_o
);

  logic                                  enable;
  logic [dram_cfg_pkg::MEM_AW-1:0]       base;
  logic [dram_regs_pkg::LIMIT_W-1:0]     limit;

  logic                                  mem_read_v;
  logic [dram_cfg_pkg::MEM_AW-1:0]       mem_read_paddr;
  logic                                  mem_write_v;
  logic [dram_cfg_pkg::MEM_AW-1:0]       mem_write_paddr;
  logic                                  rd_reject;
  logic                                  wr_reject;

  dram_chan_regs u_regs (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .rd_accept_i (mem_read_v),
    .wr_accept_i (wdata_yumi_o),   // acknowledge is the accepted write
    .rd_reject_i (rd_reject),
    .wr_reject_i (wr_reject),
    .enable_o    (enable),
    .base_o      (base),
    .limit_o     (limit)
  );

  dram_addr_xlate u_xlate (
    .enable_i          (enable),
    .base_i            (base),
    .limit_i           (limit),
    .read_v_i          (read_v_i),
    .read_addr_i       (read_addr_i),
    .write_v_i         (write_v_i),
    .write_addr_i      (write_addr_i),
    .wdata_v_i         (wdata_v_i),
    .mem_read_v_o      (mem_read_v),
    .mem_read_paddr_o  (mem_read_paddr),
    .mem_write_v_o     (mem_write_v),
    .mem_write_paddr_o (mem_write_paddr),
    .rd_reject_o       (rd_reject),
    .wr_reject_o       (wr_reject)
  );

  dram_mem_model u_mem (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .read_v_i      (mem_read_v),
    .read_paddr_i  (mem_read_paddr),
    .rdata_v_o     (rdata_v_o),
    .rdata_o       (rdata_o),
    .write_v_i     (mem_write_v),
    .write_paddr_i (mem_write_paddr),
    .wdata_i       (wdata_i),
    .wdata_yumi_o  (wdata_yumi_o)
  );

endmodule

`default_nettype wire

// ==== logic/dram_mem_model.sv ====
// dram channel byte array memory
// one-cycle read, same-cycle acknowledged write
`timescale 1ns/10ps
`default_nettype none

module dram_mem_model (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_i,

  // read port
  input  wire logic                                  read_v_i,
  input  wire logic [dram_cfg_pkg::MEM_AW-1:0]       read_paddr_i,
  output logic                                       rdata_v_o,
  output logic      [dram_cfg_pkg::DATA_W-1:0]       rdata_o,

  // write port
  input  wire logic                                  write_v_i,
  input  wire logic [dram_cfg_pkg::MEM_AW-1:0]       write_paddr_i,
  input  wire logic [dram_cfg_pkg::DATA_W-1:0]       wdata_i,
  output logic                                       wdata_yumi_o
);

  localparam int LANES = dram_cfg_pkg::BYTES_PER_WORD;

  logic [7:0]                          mem [dram_cfg_pkg::MEM_BYTES];

  logic [dram_cfg_pkg::MEM_AW-1:0]     rd_idx [LANES];  // per-lane byte index
  logic [dram_cfg_pkg::MEM_AW-1:0]     wr_idx [LANES];
  logic [dram_cfg_pkg::DATA_W-1:0]     rd_word;
  logic                                write_ok;
  logic                                rdata_v_q;
  logic [dram_cfg_pkg::DATA_W-1:0]     rdata_q;

  // address pattern fill, contents survive reset
  initial begin
    for (int i = 0; i < dram_cfg_pkg::MEM_BYTES; i++) begin
      mem[i] = dram_cfg_pkg::init_byte(dram_cfg_pkg::MEM_AW'(i));
    end
  end

  // lanes are little endian and wrap at the end of the array
  for (genvar g = 0; g < LANES; g++) begin : g_lane
    assign rd_idx[g] = read_paddr_i + dram_cfg_pkg::MEM_AW'(g);
    assign wr_idx[g] = write_paddr_i + dram_cfg_pkg::MEM_AW'(g);
    assign rd_word[g*8 +: 8] = mem[rd_idx[g]];
  end

  // no write is taken while reset is high
  assign write_ok     = write_v_i && !rst_i;
  assign wdata_yumi_o = write_ok;

  // bytes land on the edge the write is acknowledged
  always @(posedge clk_i) begin
    if (write_ok) begin
      for (int i = 0; i < LANES; i++) begin
        mem[wr_idx[i]] <= wdata_i[i*8 +: 8];
      end
    end
  end

  // read valid follows the command by one cycle
  always_ff @(posedge clk_i) begin
    if (rst_i)
      rdata_v_q <= 1'b0;
    else
      rdata_v_q <= read_v_i;
  end

  // sampled before this edge's write, so an overlap returns old bytes
  always_ff @(posedge clk_i) begin
    if (read_v_i)
      rdata_q <= rd_word;
  end

  assign rdata_v_o = rdata_v_q;
  assign rdata_o   = rdata_q;

endmodule

`default_nettype wire

// ==== logic/dram_regs_pkg.sv ====
// dram channel register map
`default_nettype none

package dram_regs_pkg;

  localparam int CFG_AW = 3;   // register index width
  localparam int CFG_DW = 32;  // register data width
  localparam int CNT_W = 32;   // event counter width

  // limit holds a full 64 KB window, so one bit wider than an address
  localparam int LIMIT_W = dram_cfg_pkg::ADDR_W + 1;

  // register indices
  localparam logic [CFG_AW-1:0] REG_CTRL = 3'd0;     // bit 0 is enable
  localparam logic [CFG_AW-1:0] REG_BASE = 3'd1;     // low MEM_AW bits
  localparam logic [CFG_AW-1:0] REG_LIMIT = 3'd2;    // window size in bytes
  localparam logic [CFG_AW-1:0] REG_RD_CNT = 3'd3;   // read only
  localparam logic [CFG_AW-1:0] REG_WR_CNT = 3'd4;   // read only
  localparam logic [CFG_AW-1:0] REG_ERR_CNT = 3'd5;  // any write clears

  // reset values
  localparam logic [dram_cfg_pkg::MEM_AW-1:0] BASE_RESET = '0;
  localparam logic [LIMIT_W-1:0] LIMIT_RESET = LIMIT_W'(4096);

endpackage

`default_nettype wire

// ==== project.f ====
logic/dram_cfg_pkg.sv
logic/dram_regs_pkg.sv
logic/dram_chan_regs.sv
logic/dram_addr_xlate.sv
logic/dram_mem_model.sv
logic/dram_channel_top.sv
verification/dram_channel_tb.sv

// ==== verification/dram_channel_tb.sv ====
// dram channel testbench
// random stimulus against a reference model
`timescale 1ns/10ps
`default_nettype none

module dram_channel_tb;

  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 4;
  localparam logic [31:0] SEED = 32'hdd794538;

  // test lengths in cycles set the watchdog time
  localparam int N_DISABLE = 40;
  localparam int N_FILL = 80;
  localparam int N_WRITE = 150;
  localparam int N_WINDOW = 120;
  localparam int N_READBACK = 1024;  // every word of the array
  localparam int N_COUNT = 150;
  localparam int N_OVERHEAD = 60;    // register accesses and flushes
  localparam int WATCHDOG_NS = 2 * CLK_PERIOD * (RESET_CYCLES + N_DISABLE + N_FILL +
    N_WRITE + N_WINDOW + N_READBACK + N_COUNT + N_OVERHEAD);

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic        read_v_i;
  logic [15:0] read_addr_i;
  logic        write_v_i;
  logic [15:0] write_addr_i;
  logic        wdata_v_i;
  logic [31:0] wdata_i;
  logic        wdata_yumi_o;
  logic        rdata_v_o;
  logic [31:0] rdata_o;
  logic        cfg_we_i;
  logic [2:0]  cfg_addr_i;
  logic [31:0] cfg_wdata_i;
  logic [31:0] cfg_rdata_o;

  // reference model state
  logic [7:0]  mem_m [4096];
  logic        en_m;
  logic [11:0] base_m;
  logic [16:0] limit_m;
  logic [31:0] rd_cnt_m;
  logic [31:0] wr_cnt_m;
  logic [31:0] err_cnt_m;

  logic [32:0] exp_q [$];  // {valid, data} expected in the following cycle
  logic [32:0] pending;    // prediction made in the current cycle
  logic [32:0] exp_entry;
  int          pass_cnt;
  int          fail_cnt;
  int          start_fail;

  dram_channel_top u_dut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .read_v_i     (read_v_i),
    .read_addr_i  (read_addr_i),
    .write_v_i    (write_v_i),
    .write_addr_i (write_addr_i),
    .wdata_v_i    (wdata_v_i),
    .wdata_i      (wdata_i),
    .wdata_yumi_o (wdata_yumi_o),
    .rdata_v_o    (rdata_v_o),
    .rdata_o      (rdata_o),
    .cfg_we_i     (cfg_we_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .cfg_rdata_o  (cfg_rdata_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // word fits when its last byte is below the limit
  function automatic bit in_window(input logic [15:0] addr, input logic [16:0] limit);
    return (int'(addr) + 4) <= int'(limit);
  endfunction

  function automatic logic [11:0] phys_addr(input logic [11:0] base, input logic [15:0] addr);
    return 12'((int'(base) + int'(addr)) % 4096);
  endfunction

  function automatic logic [31:0] model_read(input logic [11:0] pa);
    logic [31:0] word;
    for (int lane = 0; lane < 4; lane++) begin
      word[lane*8 +: 8] = mem_m[(int'(pa) + lane) % 4096];  // little endian with wraparound
    end
    return word;
  endfunction

  function automatic logic [31:0] reg_value(input logic [2:0] idx);
    case (idx)
      3'd0:    return {31'b0, en_m};
      3'd1:    return {20'b0, base_m};
      3'd2:    return {15'b0, limit_m};
      3'd3:    return rd_cnt_m;
      3'd4:    return wr_cnt_m;
      3'd5:    return err_cnt_m;
      default: return 32'h0;  // unmapped
    endcase
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  // one clock of stimulus, model update and same-cycle checks
  task automatic run_cycle(input logic rv, input logic [15:0] ra, input logic wv,
                           input logic [15:0] wa, input logic dv, input logic [31:0] wd,
                           input logic cwe, input logic [2:0] ca, input logic [31:0] cwd);
    logic rd_ok;
    logic rd_rej;
    logic wr_ok;
    logic wr_rej;
    logic [11:0] wpa;
    @(posedge clk_i);
    exp_q.push_back(pending);
    pending = '0;
    read_v_i     <= rv;
    read_addr_i  <= ra;
    write_v_i    <= wv;
    write_addr_i <= wa;
    wdata_v_i    <= dv;
    wdata_i      <= wd;
    cfg_we_i     <= cwe;
    cfg_addr_i   <= ca;
    cfg_wdata_i  <= cwd;
    @(negedge clk_i);
    rd_ok  = en_m && rv && in_window(ra, limit_m);
    rd_rej = en_m && rv && !in_window(ra, limit_m);
    wr_ok  = en_m && wv && dv && in_window(wa, limit_m);
    wr_rej = en_m && wv && dv && !in_window(wa, limit_m);
    check_value(32'(wdata_yumi_o), 32'(wr_ok), "write acknowledge");
    check_value(cfg_rdata_o, reg_value(ca), $sformatf("register %0d readback", ca));
    if (rd_ok)
      pending = {1'b1, model_read(phys_addr(base_m, ra))};  // old bytes on overlap
    if (wr_ok) begin
      wpa = phys_addr(base_m, wa);
      for (int lane = 0; lane < 4; lane++) begin
        mem_m[(int'(wpa) + lane) % 4096] = wd[lane*8 +: 8];
      end
    end
    rd_cnt_m = rd_cnt_m + 32'(rd_ok);
    wr_cnt_m = wr_cnt_m + 32'(wr_ok);
    if (cwe && ca == 3'd5)
      err_cnt_m = 32'h0;  // clear beats a same-cycle reject
    else
      err_cnt_m = err_cnt_m + 32'(rd_rej) + 32'(wr_rej);
    if (cwe && ca == 3'd0)
      en_m = cwd[0];
    if (cwe && ca == 3'd1)
      base_m = cwd[11:0];
    if (cwe && ca == 3'd2)
      limit_m = cwd[16:0];
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      run_cycle(1'b0, 16'h0, 1'b0, 16'h0, 1'b0, 32'h0, 1'b0, 3'd0, 32'h0);
    end
  endtask

  task automatic cfg_write(input logic [2:0] idx, input logic [31:0] data);
    run_cycle(1'b0, 16'h0, 1'b0, 16'h0, 1'b0, 32'h0, 1'b1, idx, data);
  endtask

  task automatic cfg_peek(input logic [2:0] idx);
    run_cycle(1'b0, 16'h0, 1'b0, 16'h0, 1'b0, 32'h0, 1'b0, idx, 32'h0);
  endtask

  task automatic random_cycle(input int span, input bit with_write);
    logic        rv;
    logic        wv;
    logic        dv;
    logic [15:0] ra;
    logic [15:0] wa;
    logic [31:0] wd;
    rv = 1'($urandom);
    ra = 16'($urandom % span);
    wv = with_write ? 1'($urandom) : 1'b0;
    wa = 16'($urandom % span);
    dv = 1'($urandom);
    wd = $urandom;
    run_cycle(rv, ra, wv, wa, dv, wd, 1'b0, 3'($urandom), 32'h0);
  endtask

  task automatic report_test(input string name);
    $display("test %s finished with %0d errors", name, fail_cnt - start_fail);
    start_fail = fail_cnt;
  endtask

  // read data is due one cycle after the command
  always @(negedge clk_i) begin
    if (!rst_i) begin
      exp_entry = (exp_q.size() > 0) ? exp_q.pop_front() : 33'h0;
      check_value(32'(rdata_v_o), 32'(exp_entry[32]), "read data valid");
      if (exp_entry[32])
        check_value(rdata_o, exp_entry[31:0], "read data");
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    rst_i        = 1'b1;
    read_v_i     = 1'b0;
    read_addr_i  = '0;
    write_v_i    = 1'b0;
    write_addr_i = '0;
    wdata_v_i    = 1'b0;
    wdata_i      = '0;
    cfg_we_i     = 1'b0;
    cfg_addr_i   = '0;
    cfg_wdata_i  = '0;
    for (int i = 0; i < 4096; i++) begin
      mem_m[i] = 8'(i);  // each byte holds its own low address bits
    end
    en_m       = 1'b0;
    base_m     = 12'h0;
    limit_m    = 17'd4096;
    rd_cnt_m   = '0;
    wr_cnt_m   = '0;
    err_cnt_m  = '0;
    pending    = '0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    start_fail = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;

    // reset values and then commands while disabled
    for (int i = 0; i < 8; i++) begin
      cfg_peek(3'(i));
    end
    for (int i = 0; i < N_DISABLE; i++) begin
      random_cycle(65536, 1'b1);
    end
    report_test("reset and disable");

    cfg_write(3'd0, 32'h1);
    for (int i = 0; i < N_FILL; i++) begin
      random_cycle(4093, 1'b0);  // unaligned reads inside the window
    end
    report_test("initial fill and read latency");

    for (int i = 0; i < N_WRITE; i++) begin
      random_cycle((i % 2 == 0) ? 64 : 4096, 1'b1);  // small span forces overlaps
    end
    report_test("write then read back");

    cfg_write(3'd1, 32'($urandom_range(4095, 0)));
    cfg_write(3'd2, 32'($urandom_range(65536, 4)));
    for (int i = 0; i < N_WINDOW; i++) begin
      random_cycle((i % 2 == 0) ? int'(limit_m) : 65536, 1'b1);
    end
    // word that wraps at the top of the array, read in the cycle it is written
    cfg_write(3'd1, 32'hffe);
    cfg_write(3'd2, 32'd4096);
    run_cycle(1'b1, 16'h0, 1'b1, 16'h0, 1'b1, $urandom, 1'b0, 3'd1, 32'h0);
    run_cycle(1'b1, 16'h0, 1'b0, 16'h0, 1'b0, 32'h0, 1'b0, 3'd1, 32'h0);
    cfg_write(3'd1, 32'h0);
    cfg_write(3'd2, 32'd4096);
    for (int w = 0; w < N_READBACK; w++) begin
      run_cycle(1'b1, 16'(w * 4), 1'b0, 16'h0, 1'b0, 32'h0, 1'b0, 3'd0, 32'h0);
    end
    report_test("window and base");

    cfg_write(3'd5, 32'h0);
    cfg_write(3'd1, 32'($urandom_range(4095, 0)));
    cfg_write(3'd2, 32'd256);
    for (int i = 0; i < N_COUNT; i++) begin
      random_cycle(512, 1'b1);  // about half rejected
    end
    // two rejects in one cycle
    run_cycle(1'b1, 16'h0300, 1'b1, 16'h0400, 1'b1, $urandom, 1'b0, 3'd5, 32'h0);
    run_cycle(1'b1, 16'h01fd, 1'b1, 16'hfffe, 1'b1, $urandom, 1'b0, 3'd5, 32'h0);
    cfg_peek(3'd3);
    cfg_peek(3'd4);
    cfg_peek(3'd5);
    cfg_write(3'd3, 32'hffff);  // read only so the write is ignored
    cfg_write(3'd4, 32'h1234);
    cfg_peek(3'd3);
    cfg_peek(3'd4);
    // clear with a double reject in the same cycle
    run_cycle(1'b1, 16'h0300, 1'b1, 16'h0400, 1'b1, $urandom, 1'b1, 3'd5, 32'h0);
    cfg_peek(3'd5);
    idle_cycles(2);
    report_test("counters");

    @(posedge clk_i);
    $display("passed checks: %0d, failed checks: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
